// ==== hw/cu_pkg.sv ====
// Shared definitions for the graph sum cluster
// Widths, edge/job/write record types and the scaling defaults

package cu_pkg;

	localparam int VERTEX_ID_BITS = 8;
	localparam int DEGREE_BITS    = 8;
	localparam int DATA_BITS      = 16;
	localparam int SUM_BITS       = 24;
	localparam int COUNT_BITS     = 16;

	// Full width of data times weight before the shift
	localparam int PRODUCT_BITS        = 2 * DATA_BITS;
	localparam int DEFAULT_SCALE_SHIFT = 8;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic [DATA_BITS-1:0] weight;
	} edge_t;

	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0] id;
		logic [DEGREE_BITS-1:0]    degree;
	} job_t;

	// One finished vertex, tagged with the kernel that produced it
	typedef struct packed {
		logic                      cu_id;
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		logic [SUM_BITS-1:0]       sum;
	} write_rec_t;

endpackage

// ==== hw/sync_fifo.sv ====
// Synchronous FIFO with a typed payload
// Head is shown on data_out, valid pulses the cycle after a pop

`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     full,
	output logic     alfull,
	output logic     empty,
	output logic     valid
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
	localparam logic [PTR_BITS:0]   DEPTH_CNT = (PTR_BITS + 1)'(DEPTH);

	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	// Pushes into a full buffer and pops from an empty one are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == DEPTH_CNT);
	assign alfull   = (count >= DEPTH_CNT - 1'b1);
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

// ==== hw/edge_weight_scaler.sv ====
// Edge weight scaler, three pipeline stages
// Latches the edge, multiplies data by weight, then shifts the product down

`timescale 1ns/100ps

module edge_weight_scaler #(
	parameter int SCALE_SHIFT = cu_pkg::DEFAULT_SCALE_SHIFT
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,
	input  logic                         in_valid,
	input  cu_pkg::edge_t                in_edge,
	output logic                         out_valid,
	output logic [cu_pkg::DATA_BITS-1:0] scaled
);

	logic                            s1_valid;
	logic                            s2_valid;
	cu_pkg::edge_t                   s1_edge;
	logic [cu_pkg::PRODUCT_BITS-1:0] s2_product;

	// Valid chain, frozen as a whole while enable is low
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (enable) begin
			s1_valid  <= in_valid;
			s2_valid  <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Payload stages
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (enable) begin
			s1_edge    <= in_edge;
			s2_product <= s1_edge.data * s1_edge.weight;
			// Keep only the low data bits of the shifted product
			scaled     <= cu_pkg::DATA_BITS'(s2_product >> SCALE_SHIFT);
		end
	end

endmodule

// ==== hw/vertex_sum_kernel.sv ====
// Vertex sum kernel
// Pulls degree edges per job, sums the scaled values and queues one write record

`timescale 1ns/100ps

module vertex_sum_kernel #(
	parameter int CU_ID       = 0,
	parameter int SCALE_SHIFT = cu_pkg::DEFAULT_SCALE_SHIFT,
	parameter int WRITE_DEPTH = 4
) (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          enable,
	input  logic                          job_valid,
	input  cu_pkg::job_t                  job_in,
	output logic                          job_busy,
	input  logic                          edge_empty,
	input  cu_pkg::edge_t                 edge_head,
	output logic                          edge_pop,
	input  logic                          out_alfull,
	output logic                          wr_request,
	input  logic                          wr_grant,
	output cu_pkg::write_rec_t            wr_rec,
	input  logic                          resp_strobe,
	output logic [cu_pkg::COUNT_BITS-1:0] edge_count,
	output logic [cu_pkg::COUNT_BITS-1:0] resp_count
);

	logic                           rstn_meta;
	logic                           rstn_sync;
	cu_pkg::job_t                   job_q;
	logic                           job_load;
	logic                           pop_req;
	logic                           pop_taken;
	logic [cu_pkg::DEGREE_BITS-1:0] req_cnt;
	logic [cu_pkg::DEGREE_BITS:0]   issued_next;
	cu_pkg::edge_t                  edge_q;
	logic                           edge_held;
	logic                           scale_in_valid;
	logic                           scaled_valid;
	logic [cu_pkg::DATA_BITS-1:0]   scaled;
	logic [cu_pkg::SUM_BITS-1:0]    sum_q;
	logic [cu_pkg::SUM_BITS-1:0]    sum_next;
	logic [cu_pkg::DEGREE_BITS-1:0] sum_cnt;
	logic                           sum_done;
	logic                           wq_push;
	cu_pkg::write_rec_t             wq_rec;
	logic                           wq_alfull;
	logic                           wq_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rstn_meta <= 1'b0;
			rstn_sync <= 1'b0;
		end else begin
			rstn_meta <= 1'b1;
			rstn_sync <= rstn_meta;
		end
	end

	assign job_load  = job_valid && !job_busy;
	assign edge_pop  = pop_req && enable;
	assign pop_taken = edge_pop && !edge_empty;
	// Edges requested once the pop of this cycle lands
	assign issued_next = {1'b0, req_cnt} + (cu_pkg::DEGREE_BITS + 1)'(pop_taken);

	assign scale_in_valid = enable && edge_held;
	assign sum_next       = sum_q + cu_pkg::SUM_BITS'(scaled);
	assign sum_done       = enable && scaled_valid &&
		(cu_pkg::DEGREE_BITS'(sum_cnt + 1'b1) == job_q.degree);

	assign wr_request = !wq_empty && !out_alfull;

	//////////////////////////////////////////////////////////////////////
	// Job, edge requests and accumulation
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn_sync) begin
		if (!rstn_sync) begin
			job_busy   <= 1'b0;
			pop_req    <= 1'b0;
			req_cnt    <= '0;
			edge_held  <= 1'b0;
			sum_q      <= '0;
			sum_cnt    <= '0;
			wq_push    <= 1'b0;
			edge_count <= '0;
			resp_count <= '0;
		end else begin
			pop_req <= enable && job_busy && !edge_empty && !wq_alfull &&
				(issued_next < {1'b0, job_q.degree});
			// A popped edge waits here while enable is low
			if (pop_taken)
				edge_held <= 1'b1;
			else if (enable)
				edge_held <= 1'b0;
			if (job_load)
				req_cnt <= '0;
			else if (pop_taken)
				req_cnt <= req_cnt + 1'b1;

			wq_push <= sum_done;
			if (job_load) begin
				job_busy <= 1'b1;
			end else if (sum_done) begin
				job_busy <= 1'b0;
				sum_q    <= '0;
				sum_cnt  <= '0;
			end else if (enable && scaled_valid) begin
				sum_q   <= sum_next;
				sum_cnt <= sum_cnt + 1'b1;
			end

			if (enable && scaled_valid)
				edge_count <= edge_count + 1'b1;
			if (resp_strobe)
				resp_count <= resp_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (job_load)
			job_q <= job_in;
		if (pop_taken)
			edge_q <= edge_head;
		if (sum_done) begin
			wq_rec.cu_id     <= 1'(CU_ID);
			wq_rec.vertex_id <= job_q.id;
			wq_rec.sum       <= sum_next;
		end
	end

	edge_weight_scaler #(
		.SCALE_SHIFT(SCALE_SHIFT)
	) scaler_inst (
		.clock    (clock),
		.rstn     (rstn_sync),
		.enable   (enable),
		.in_valid (scale_in_valid),
		.in_edge  (edge_q),
		.out_valid(scaled_valid),
		.scaled   (scaled)
	);

	// Finished records wait here for a write grant
	sync_fifo #(
		.payload_t(cu_pkg::write_rec_t),
		.DEPTH    (WRITE_DEPTH)
	) write_queue_inst (
		.clock   (clock),
		.rstn    (rstn_sync),
		.push    (wq_push),
		.data_in (wq_rec),
		.pop     (wr_grant),
		.data_out(wr_rec),
		.full    (),
		.alfull  (wq_alfull),
		.empty   (wq_empty),
		.valid   ()
	);

endmodule

// ==== hw/cu_write_port.sv ====
// Shared write port for the two kernels
// Round-robin grants into one output buffer, responses routed back per kernel

`timescale 1ns/100ps

module cu_write_port #(
	parameter int OUT_DEPTH = 8
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic [1:0]                     wr_request,
	input  cu_pkg::write_rec_t [1:0]       wr_rec,
	output logic [1:0]                     wr_grant,
	output logic                           out_alfull,
	input  logic                           out_pop,
	output logic                           out_valid,
	output cu_pkg::write_rec_t             out_rec,
	input  logic                           resp_valid,
	input  logic                           resp_cu,
	output logic [1:0]                     resp_strobe
);

	logic               rr_ptr;
	logic [1:0]         eligible;
	logic [1:0]         grant_next;
	logic               out_push;
	cu_pkg::write_rec_t push_rec;
	logic               out_empty;

	// A kernel granted this cycle may be popping its last record
	assign eligible = wr_request & ~wr_grant;

	always_comb begin
		grant_next = 2'b00;
		if (!out_alfull) begin
			if (eligible[rr_ptr])
				grant_next[rr_ptr] = 1'b1;
			else if (eligible[!rr_ptr])
				grant_next[!rr_ptr] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_grant    <= 2'b00;
			rr_ptr      <= 1'b0;
			resp_strobe <= 2'b00;
		end else begin
			wr_grant <= grant_next;
			// Priority moves to the other kernel after a grant
			if (|grant_next)
				rr_ptr <= grant_next[0];
			resp_strobe <= {resp_valid && resp_cu, resp_valid && !resp_cu};
		end
	end

	assign out_push  = |wr_grant;
	assign push_rec  = wr_grant[1] ? wr_rec[1] : wr_rec[0];
	assign out_valid = !out_empty;

	sync_fifo #(
		.payload_t(cu_pkg::write_rec_t),
		.DEPTH    (OUT_DEPTH)
	) out_buffer_inst (
		.clock   (clock),
		.rstn    (rstn),
		.push    (out_push),
		.data_in (push_rec),
		.pop     (out_pop),
		.data_out(out_rec),
		.full    (),
		.alfull  (out_alfull),
		.empty   (out_empty),
		.valid   ()
	);

endmodule

// ==== hw/sum_cluster_top.sv ====
// Graph sum cluster top level
// Two edge queues and sum kernels sharing one write port

`timescale 1ns/100ps

module sum_cluster_top #(
	parameter int SCALE_SHIFT = cu_pkg::DEFAULT_SCALE_SHIFT,
	parameter int EDGE_DEPTH  = 8,
	parameter int WRITE_DEPTH = 4,
	parameter int OUT_DEPTH   = 8
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                enable,
	input  logic [1:0]                          edge_push,
	input  cu_pkg::edge_t [1:0]                 edge_in,
	output logic [1:0]                          edge_full,
	input  logic [1:0]                          job_valid,
	input  cu_pkg::job_t [1:0]                  job_in,
	output logic [1:0]                          job_busy,
	input  logic                                out_pop,
	output logic                                out_valid,
	output cu_pkg::write_rec_t                  out_rec,
	input  logic                                resp_valid,
	input  logic                                resp_cu,
	output logic [1:0][cu_pkg::COUNT_BITS-1:0]  edge_count,
	output logic [1:0][cu_pkg::COUNT_BITS-1:0]  resp_count
);

	logic [1:0]               edge_empty;
	cu_pkg::edge_t [1:0]      edge_head;
	logic [1:0]               edge_pop;
	logic [1:0]               wr_request;
	logic [1:0]               wr_grant;
	cu_pkg::write_rec_t [1:0] wr_rec;
	logic                     out_alfull;
	logic [1:0]               resp_strobe;

	//////////////////////////////////////////////////////////////////////
	// Per-kernel edge queue and kernel
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_cu
		sync_fifo #(
			.payload_t(cu_pkg::edge_t),
			.DEPTH    (EDGE_DEPTH)
		) edge_queue_inst (
			.clock   (clock),
			.rstn    (rstn),
			.push    (edge_push[i]),
			.data_in (edge_in[i]),
			.pop     (edge_pop[i]),
			.data_out(edge_head[i]),
			.full    (edge_full[i]),
			.alfull  (),
			.empty   (edge_empty[i]),
			.valid   ()
		);

		vertex_sum_kernel #(
			.CU_ID      (i),
			.SCALE_SHIFT(SCALE_SHIFT),
			.WRITE_DEPTH(WRITE_DEPTH)
		) kernel_inst (
			.clock      (clock),
			.rstn       (rstn),
			.enable     (enable),
			.job_valid  (job_valid[i]),
			.job_in     (job_in[i]),
			.job_busy   (job_busy[i]),
			.edge_empty (edge_empty[i]),
			.edge_head  (edge_head[i]),
			.edge_pop   (edge_pop[i]),
			.out_alfull (out_alfull),
			.wr_request (wr_request[i]),
			.wr_grant   (wr_grant[i]),
			.wr_rec     (wr_rec[i]),
			.resp_strobe(resp_strobe[i]),
			.edge_count (edge_count[i]),
			.resp_count (resp_count[i])
		);
	end

	cu_write_port #(
		.OUT_DEPTH(OUT_DEPTH)
	) write_port_inst (
		.clock      (clock),
		.rstn       (rstn),
		.wr_request (wr_request),
		.wr_rec     (wr_rec),
		.wr_grant   (wr_grant),
		.out_alfull (out_alfull),
		.out_pop    (out_pop),
		.out_valid  (out_valid),
		.out_rec    (out_rec),
		.resp_valid (resp_valid),
		.resp_cu    (resp_cu),
		.resp_strobe(resp_strobe)
	);

endmodule

// ==== verification/sum_cluster_checker.sv ====
// Checker for the graph sum cluster
// Reference sums per job, record order per kernel, enable freeze and counters

`timescale 1ns/100ps

module sum_cluster_checker #(
	parameter int SCALE_SHIFT = cu_pkg::DEFAULT_SCALE_SHIFT,
	parameter int EDGE_DEPTH  = 8,
	parameter int MAX_JOBS    = 16
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enable,
	input  logic [1:0]                         edge_push,
	input  logic [1:0]                         edge_full,
	input  logic [1:0]                         job_busy,
	input  logic                               out_pop,
	input  logic                               out_valid,
	input  cu_pkg::write_rec_t                 out_rec,
	input  logic                               resp_valid,
	input  logic                               resp_cu,
	input  logic [1:0][cu_pkg::COUNT_BITS-1:0] edge_count,
	input  logic [1:0][cu_pkg::COUNT_BITS-1:0] resp_count,
	output int                                 pending_jobs
);

	string                             job_name   [MAX_JOBS];
	int                                job_cu     [MAX_JOBS];
	int                                job_degree [MAX_JOBS];
	logic [cu_pkg::VERTEX_ID_BITS-1:0] job_id     [MAX_JOBS];
	logic [cu_pkg::SUM_BITS-1:0]       job_sum    [MAX_JOBS];

	// Job indices in the order each kernel was given them
	int pend_cu0 [$];
	int pend_cu1 [$];

	int edges_noted [2] = '{0, 0};
	int resp_sent   [2] = '{0, 0};
	int jobs_noted   = 0;
	int jobs_seen    = 0;
	int tests_run    = 0;
	int tests_passed = 0;
	int errors       = 0;

	logic                               prev_enable = 1'b1;
	logic [1:0]                         prev_busy   = 2'b00;
	logic [1:0][cu_pkg::COUNT_BITS-1:0] prev_edge_count = '0;

	assign pending_jobs = jobs_noted - jobs_seen;

	task note_job(input int idx, input string name, input int cu, input int id,
		input int degree);
		job_name[idx]   = name;
		job_cu[idx]     = cu;
		job_degree[idx] = degree;
		job_id[idx]     = cu_pkg::VERTEX_ID_BITS'(id);
		job_sum[idx]    = '0;
		if (cu == 0)
			pend_cu0.push_back(idx);
		else
			pend_cu1.push_back(idx);
		jobs_noted++;
	endtask

	// Scaled edge is the product shifted down, kept to the data width
	task note_edge(input int idx, input logic [cu_pkg::DATA_BITS-1:0] data,
		input logic [cu_pkg::DATA_BITS-1:0] weight);
		logic [2*cu_pkg::DATA_BITS-1:0] product;
		logic [cu_pkg::DATA_BITS-1:0]   scaled;
		product      = (2*cu_pkg::DATA_BITS)'(data) * (2*cu_pkg::DATA_BITS)'(weight);
		scaled       = cu_pkg::DATA_BITS'(product >> SCALE_SHIFT);
		job_sum[idx] = job_sum[idx] + cu_pkg::SUM_BITS'(scaled);
		edges_noted[job_cu[idx]]++;
	endtask

	task check_after_reset();
		if (out_valid !== 1'b0 || job_busy !== 2'b00) begin
			$display("** Error at %0d ns: out_valid/job_busy = %b/%b, expected 0/00",
				$time, out_valid, job_busy);
			errors++;
		end
		for (int c = 0; c < 2; c++) begin
			if (edge_count[c] !== '0) begin
				$display("** Error at %0d ns: edge_count[%0d] = %0d, expected 0",
					$time, c, edge_count[c]);
				errors++;
			end
			if (resp_count[c] !== '0) begin
				$display("** Error at %0d ns: resp_count[%0d] = %0d, expected 0",
					$time, c, resp_count[c]);
				errors++;
			end
		end
	endtask

	task check_record(input cu_pkg::write_rec_t rec);
		int idx;
		bit ok;
		idx = -1;
		ok  = 1'b1;
		if (rec.cu_id == 1'b0 && pend_cu0.size() > 0)
			idx = pend_cu0.pop_front();
		else if (rec.cu_id == 1'b1 && pend_cu1.size() > 0)
			idx = pend_cu1.pop_front();
		if (idx < 0) begin
			$display("Record from cu %0d for vertex 0x%h arrived with no job waiting for it",
				rec.cu_id, rec.vertex_id);
			errors++;
		end else begin
			if (rec.vertex_id !== job_id[idx]) begin
				$display("** Error at %0d ns: out_rec.vertex_id = 0x%h, expected 0x%h",
					$time, rec.vertex_id, job_id[idx]);
				ok = 1'b0;
				errors++;
			end
			if (rec.sum !== job_sum[idx]) begin
				$display("** Error at %0d ns: out_rec.sum = 0x%h, expected 0x%h",
					$time, rec.sum, job_sum[idx]);
				ok = 1'b0;
				errors++;
			end
			jobs_seen++;
			tests_run++;
			if (ok)
				tests_passed++;
			$display("Test %-14s cu %0d vertex 0x%h degree %0d: %s", job_name[idx],
				job_cu[idx], job_id[idx], job_degree[idx], ok ? "ok" : "mismatch");
		end
	endtask

	// Counters once every record is drained and answered
	task finish_checks(output int total_errors);
		for (int c = 0; c < 2; c++) begin
			if (edge_count[c] !== cu_pkg::COUNT_BITS'(edges_noted[c])) begin
				$display("** Error at %0d ns: edge_count[%0d] = %0d, expected %0d",
					$time, c, edge_count[c], edges_noted[c]);
				errors++;
			end
			if (resp_count[c] !== cu_pkg::COUNT_BITS'(resp_sent[c])) begin
				$display("** Error at %0d ns: resp_count[%0d] = %0d, expected %0d",
					$time, c, resp_count[c], resp_sent[c]);
				errors++;
			end
		end
		$display("Tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
		total_errors = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sampling at the falling edge, where DUT outputs are settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		int queued;
		if (rstn) begin
			if (out_pop && out_valid)
				check_record(out_rec);
			for (int c = 0; c < 2; c++) begin
				// Low enable at the last sample freezes the kernel for this cycle
				if (!prev_enable && edge_count[c] !== prev_edge_count[c]) begin
					$display("** Error at %0d ns: edge_count[%0d] = %0d, expected %0d",
						$time, c, edge_count[c], prev_edge_count[c]);
					errors++;
				end
				if (!prev_enable && prev_busy[c] && !job_busy[c]) begin
					$display("Job on cu %0d completed while enable was low", c);
					errors++;
				end
				// Edges in the queue, at most those landed and not yet summed
				queued = edges_noted[c] - int'(edge_push[c]) - int'(edge_count[c]);
				if (edge_full[c] && queued < EDGE_DEPTH) begin
					$display("** Error at %0d ns: edge_full[%0d] = 1, expected 0",
						$time, c);
					errors++;
				end
				if (resp_valid && resp_cu == 1'(c))
					resp_sent[c]++;
			end
		end
		prev_enable     = enable;
		prev_busy       = job_busy;
		prev_edge_count = edge_count;
	end

endmodule

// ==== verification/sum_cluster_tb.sv ====
// Testbench for the graph sum cluster
// Applies a job table with random edges, drains the output and answers responses

`timescale 1ns/100ps

module sum_cluster_tb;

	localparam int SCALE_SHIFT = 8;
	localparam int EDGE_DEPTH  = 8;
	localparam int DRIVE_DELAY = 10;
	localparam int HOLD_CYCLES = 48;
	localparam int NUM_ROWS    = 11;

	// Table columns
	localparam int COL_CU   = 0;
	localparam int COL_ID   = 1;
	localparam int COL_DEG  = 2;
	localparam int COL_GAP  = 3;
	localparam int COL_DUTY = 4;

	// cu, vertex id, degree, enable gap, out_pop duty in quarters (0 holds out_pop low)
	int rows [NUM_ROWS][5] = '{
		'{0, 'h11,  3,  0, 4},
		'{1, 'h22,  5,  0, 4},
		'{0, 'h33, 20,  0, 4},
		'{1, 'h44,  6, 12, 4},
		'{0, 'h55, 12,  0, 0},
		'{1, 'h66,  4,  0, 0},
		'{0, 'h67,  2,  0, 0},
		'{1, 'h68,  3,  0, 0},
		'{0, 'h77,  4,  5, 1},
		'{1, 'h88,  1,  0, 2},
		'{1, 'h99, 40,  3, 3}
	};
	string row_name [NUM_ROWS] = '{
		"single_cu0", "single_cu1", "long_cu0", "gap_cu1", "hold_cu0", "hold_cu1",
		"hold_cu0_b", "hold_cu1_b", "slow_cu0", "deg1_cu1", "wide_cu1"
	};

	logic                               clock = 1'b0;
	logic                               rstn;
	logic                               enable;
	logic [1:0]                         edge_push;
	cu_pkg::edge_t [1:0]                edge_in;
	logic [1:0]                         edge_full;
	logic [1:0]                         job_valid;
	cu_pkg::job_t [1:0]                 job_in;
	logic [1:0]                         job_busy;
	logic                               out_pop;
	logic                               out_valid;
	cu_pkg::write_rec_t                 out_rec;
	logic                               resp_valid;
	logic                               resp_cu;
	logic [1:0][cu_pkg::COUNT_BITS-1:0] edge_count;
	logic [1:0][cu_pkg::COUNT_BITS-1:0] resp_count;
	int                                 pending_jobs;

	logic [15:0] lfsr_state  = 16'd27710;
	int          cycle       = 0;
	int          pop_duty    = 4;
	int          hold_until  = 0;
	int          cycle_limit = 0;
	int          errors;

	always #50 clock = ~clock;

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic [15:0] stepped;
		stepped = state >> 1;
		if (state[0])
			stepped = stepped ^ 16'hB400;
		return stepped;
	endfunction

	// One LFSR step per bit taken
	task random_word(output logic [15:0] word);
		word = '0;
		for (int i = 0; i < 16; i++) begin
			word       = {word[14:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic int run_cycle_limit();
		int limit;
		limit = 300;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += 4 * rows[r][COL_DEG] + rows[r][COL_GAP] + 40;
			if (rows[r][COL_DUTY] == 0)
				limit += HOLD_CYCLES;
		end
		return limit;
	endfunction

	task next_cycle();
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task start_job(input int r);
		int cu;
		cu = rows[r][COL_CU];
		while (job_busy[cu])
			next_cycle();
		sum_cluster_checker_inst.note_job(r, row_name[r], cu, rows[r][COL_ID], rows[r][COL_DEG]);
		job_in[cu].id     = cu_pkg::VERTEX_ID_BITS'(rows[r][COL_ID]);
		job_in[cu].degree = cu_pkg::DEGREE_BITS'(rows[r][COL_DEG]);
		job_valid[cu]     = 1'b1;
		next_cycle();
		job_valid[cu] = 1'b0;
	endtask

	task push_edges(input int r);
		int          cu;
		int          pushed;
		logic [15:0] data;
		logic [15:0] weight;
		cu     = rows[r][COL_CU];
		pushed = 0;
		while (pushed < rows[r][COL_DEG]) begin
			if (!edge_full[cu]) begin
				random_word(data);
				random_word(weight);
				edge_in[cu].data   = data;
				edge_in[cu].weight = weight;
				edge_push[cu]      = 1'b1;
				sum_cluster_checker_inst.note_edge(r, data, weight);
				pushed++;
			end else begin
				edge_push[cu] = 1'b0;
			end
			next_cycle();
		end
		edge_push[cu] = 1'b0;
	endtask

	task hold_enable(input int gap);
		if (gap > 0) begin
			enable = 1'b0;
			repeat (gap) next_cycle();
			enable = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rstn      = 1'b0;
		enable    = 1'b1;
		edge_push = 2'b00;
		edge_in   = '0;
		job_valid = 2'b00;
		job_in    = '0;
		repeat (8) @(posedge clock);
		#DRIVE_DELAY;
		rstn = 1'b1;
		// Kernel reset synchronizer settles
		repeat (4) next_cycle();
		sum_cluster_checker_inst.check_after_reset();
		for (int r = 0; r < NUM_ROWS; r++) begin
			pop_duty = (rows[r][COL_DUTY] == 0) ? 4 : rows[r][COL_DUTY];
			if (rows[r][COL_DUTY] == 0)
				hold_until = cycle + HOLD_CYCLES;
			start_job(r);
			push_edges(r);
			hold_enable(rows[r][COL_GAP]);
		end
		pop_duty = 4;
		while (pending_jobs != 0)
			next_cycle();
		// Last response passes the registered strobe and the counter
		repeat (4) next_cycle();
		sum_cluster_checker_inst.finish_checks(errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Output drain, and one response for each record taken
	initial begin
		logic popped;
		logic popped_cu;
		out_pop    = 1'b0;
		resp_valid = 1'b0;
		resp_cu    = 1'b0;
		popped     = 1'b0;
		popped_cu  = 1'b0;
		forever begin
			@(posedge clock);
			#DRIVE_DELAY;
			resp_valid = popped;
			resp_cu    = popped_cu;
			out_pop    = (cycle >= hold_until) && ((cycle % 4) < pop_duty);
			@(negedge clock);
			popped    = out_pop && out_valid;
			popped_cu = out_rec.cu_id;
		end
	end

	initial begin
		cycle_limit = run_cycle_limit();
		while (cycle < cycle_limit) begin
			@(posedge clock);
			cycle++;
		end
		$display("Timeout after %0d cycles with %0d jobs still pending", cycle, pending_jobs);
		$display("RESULT: FAIL");
		$finish;
	end

	sum_cluster_top #(
		.SCALE_SHIFT(SCALE_SHIFT),
		.EDGE_DEPTH (EDGE_DEPTH),
		.WRITE_DEPTH(4),
		.OUT_DEPTH  (8)
	) sum_cluster_top_inst (
		.clock     (clock),
		.rstn      (rstn),
		.enable    (enable),
		.edge_push (edge_push),
		.edge_in   (edge_in),
		.edge_full (edge_full),
		.job_valid (job_valid),
		.job_in    (job_in),
		.job_busy  (job_busy),
		.out_pop   (out_pop),
		.out_valid (out_valid),
		.out_rec   (out_rec),
		.resp_valid(resp_valid),
		.resp_cu   (resp_cu),
		.edge_count(edge_count),
		.resp_count(resp_count)
	);

	sum_cluster_checker #(
		.SCALE_SHIFT(SCALE_SHIFT),
		.EDGE_DEPTH (EDGE_DEPTH),
		.MAX_JOBS   (16)
	) sum_cluster_checker_inst (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.edge_push   (edge_push),
		.edge_full   (edge_full),
		.job_busy    (job_busy),
		.out_pop     (out_pop),
		.out_valid   (out_valid),
		.out_rec     (out_rec),
		.resp_valid  (resp_valid),
		.resp_cu     (resp_cu),
		.edge_count  (edge_count),
		.resp_count  (resp_count),
		.pending_jobs(pending_jobs)
	);

endmodule

// ==== all.f ====
hw/cu_pkg.sv
hw/sync_fifo.sv
hw/edge_weight_scaler.sv
hw/vertex_sum_kernel.sv
hw/cu_write_port.sv
hw/sum_cluster_top.sv
verification/sum_cluster_checker.sv
verification/sum_cluster_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module sum_cluster_tb -f all.f

sim:
	verilator --binary --timing --top-module sum_cluster_tb -f all.f \
		--Mdir obj_dir -o sum_cluster_sim
	@out="$$(./obj_dir/sum_cluster_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
